//--- verilog/soc_pkg.sv
package soc_pkg;

  // timer block layout
  localparam int NUM_TIMERS = 4;
  localparam int TIMER_IDX_W = 2;

  // address map, bits 31..28 select the region
  localparam logic [3:0] TIMER_REGION = 4'h4;

  // exception codes presented to the cpu
  typedef enum logic [3:0] {
    EXC_NONE   = 4'd0,
    EXC_MMU    = 4'd2,
    EXC_TIMER0 = 4'd4,
    EXC_TIMER1 = 4'd5,
    EXC_TIMER2 = 4'd6,
    EXC_TIMER3 = 4'd7
  } exc_code_e;

  // timer register offsets, address bits 3..2
  typedef enum logic [1:0] {
    TREG_CTRL    = 2'd0,
    TREG_COMPARE = 2'd1,
    TREG_COUNT   = 2'd2
  } timer_reg_e;

  // which path answers the current access
  typedef enum logic [1:0] {
    CS_NONE,
    CS_TIMER,
    CS_FAULT
  } chipsel_e;

endpackage

//--- verilog/wb_slave_if.sv
`timescale 1ns/1ps

interface wb_slave_if;

  logic                    stb;
  logic                    we;
  soc_pkg::timer_reg_e     adr;
  logic [31:0]             dat_w;
  logic [3:0]              sel;
  logic [31:0]             dat_r;
  logic                    ack;
  logic                    irq;

  // decoder side
  modport fabric (
    output stb, we, adr, dat_w, sel
  );

  // timer side
  modport slave (
    input  stb, we, adr, dat_w, sel,
    output dat_r, ack, irq
  );

  // return path only looks at the responses
  modport monitor (
    input dat_r, ack, irq
  );

endinterface

//--- verilog/addr_decoder.sv
`timescale 1ns/1ps

module addr_decoder (
  input  logic                cyc_i,
  input  logic                we_i,
  input  logic                supervisor_i,
  input  logic [31:0]         adr_i,
  input  logic [31:0]         dat_i,
  input  logic [3:0]          sel_i,
  output soc_pkg::chipsel_e   cs_o,
  output logic                fault_o,
  wb_slave_if.fabric          slv [soc_pkg::NUM_TIMERS]
);

  logic                            region_ok;
  logic                            user_write;
  logic [soc_pkg::TIMER_IDX_W-1:0] timer_idx;

  assign region_ok  = (adr_i[31:28] == soc_pkg::TIMER_REGION);
  assign user_write = we_i & ~supervisor_i;
  assign timer_idx  = adr_i[5:4];

  // protection check, only while a cycle is open
  assign fault_o = cyc_i & (~region_ok | user_write);

  always_comb
  begin
    if (!cyc_i)
      cs_o = soc_pkg::CS_NONE;
    else if (fault_o)
      cs_o = soc_pkg::CS_FAULT;
    else
      cs_o = soc_pkg::CS_TIMER;
  end

  for (genvar i = 0; i < soc_pkg::NUM_TIMERS; i++)
  begin : g_slv
    // a faulting access never reaches a timer
    assign slv[i].stb   = cyc_i & ~fault_o & (timer_idx == soc_pkg::TIMER_IDX_W'(i));
    assign slv[i].we    = we_i;
    assign slv[i].adr   = soc_pkg::timer_reg_e'(adr_i[3:2]);
    assign slv[i].dat_w = dat_i;
    assign slv[i].sel   = sel_i;
  end

endmodule

//--- verilog/timer_unit.sv
`timescale 1ns/1ps

module timer_unit (
  input  logic        sysclock,
  input  logic        rst_i,
  wb_slave_if.slave   bus
);

  logic        enable;
  logic        pending;
  logic [31:0] compare;
  logic [31:0] count;
  logic [31:0] rd_data;
  logic        access;
  logic        wr;
  logic        hit;
  logic        clr_pending;

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                              input logic [31:0] new_val,
                                              input logic [3:0]  sel);
    logic [31:0] result;
    result = old_val;
    for (int b = 0; b < 4; b++)
    begin
      if (sel[b])
        result[b*8 +: 8] = new_val[b*8 +: 8];
    end
    return result;
  endfunction

  // one access per strobe, ack low in between
  assign access = bus.stb & ~bus.ack;
  assign wr     = access & bus.we;

  assign hit = enable & (count == compare);

  // write 1 to clear
  assign clr_pending = wr & (bus.adr == soc_pkg::TREG_CTRL) & bus.sel[0] & bus.dat_w[1];

  always_comb
  begin
    case (bus.adr)
      soc_pkg::TREG_CTRL:    rd_data = {30'h0, pending, enable};
      soc_pkg::TREG_COMPARE: rd_data = compare;
      soc_pkg::TREG_COUNT:   rd_data = count;
      default:               rd_data = 32'h0;
    endcase
  end

  always_ff @(posedge sysclock or posedge rst_i)
  begin
    if (rst_i)
    begin
      enable  <= 1'b0;
      pending <= 1'b0;
      compare <= 32'h0;
      count   <= 32'h0;
      bus.ack <= 1'b0;
    end
    else
    begin
      bus.ack <= access;
      if (wr && bus.adr == soc_pkg::TREG_CTRL && bus.sel[0])
        enable <= bus.dat_w[0];
      // a new match wins over a clear in the same cycle
      if (hit)
        pending <= 1'b1;
      else if (clr_pending)
        pending <= 1'b0;
      if (wr && bus.adr == soc_pkg::TREG_COMPARE)
        compare <= merge_bytes(compare, bus.dat_w, bus.sel);
      if (wr && bus.adr == soc_pkg::TREG_COUNT)
        count <= merge_bytes(count, bus.dat_w, bus.sel);
      else if (hit)
        count <= 32'h0;
      else if (enable)
        count <= count + 32'h1;
    end
  end

  // zero outside the ack cycle so the return path can OR
  always_ff @(posedge sysclock)
  begin
    if (access && !bus.we)
      bus.dat_r <= rd_data;
    else
      bus.dat_r <= 32'h0;
  end

  assign bus.irq = pending;

endmodule

//--- verilog/bus_return_irq.sv
`timescale 1ns/1ps

module bus_return_irq (
  input  logic                sysclock,
  input  logic                rst_i,
  input  logic                cyc_i,
  input  logic                int_en_i,
  input  soc_pkg::chipsel_e   cs_i,
  input  logic                fault_i,
  wb_slave_if.monitor         slv [soc_pkg::NUM_TIMERS],
  output logic [31:0]         dat_o,
  output logic                ack_o,
  output soc_pkg::exc_code_e  interrupt_o
);

  logic [31:0]                    t_dat [soc_pkg::NUM_TIMERS];
  logic [soc_pkg::NUM_TIMERS-1:0] t_ack;
  logic [soc_pkg::NUM_TIMERS-1:0] t_irq;
  logic [31:0]                    timer_dat;
  logic                           fault_ack;

  for (genvar i = 0; i < soc_pkg::NUM_TIMERS; i++)
  begin : g_mon
    assign t_dat[i] = slv[i].dat_r;
    assign t_ack[i] = slv[i].ack;
    assign t_irq[i] = slv[i].irq;
  end

  always_comb
  begin
    timer_dat = 32'h0;
    for (int i = 0; i < soc_pkg::NUM_TIMERS; i++)
      timer_dat = timer_dat | t_dat[i];
  end

  // faults get their own one-cycle ack
  always_ff @(posedge sysclock or posedge rst_i)
  begin
    if (rst_i)
      fault_ack <= 1'b0;
    else
      fault_ack <= cyc_i & (cs_i == soc_pkg::CS_FAULT) & ~fault_ack;
  end

  assign dat_o = (cs_i == soc_pkg::CS_TIMER) ? timer_dat : 32'h0;
  assign ack_o = ((cs_i == soc_pkg::CS_TIMER) & (|t_ack)) |
                 ((cs_i == soc_pkg::CS_FAULT) & fault_ack);

  // fault first, then highest timer index
  always_comb
  begin
    interrupt_o = soc_pkg::EXC_NONE;
    if (int_en_i)
    begin
      if (fault_i)
        interrupt_o = soc_pkg::EXC_MMU;
      else
        for (int i = 0; i < soc_pkg::NUM_TIMERS; i++)
          if (t_irq[i])
            interrupt_o = soc_pkg::exc_code_e'(soc_pkg::EXC_TIMER0 + 4'(i));
    end
  end

endmodule

//--- verilog/soc_fabric.sv
`timescale 1ns/1ps

module soc_fabric (
  input  logic        sysclock,
  input  logic        rst_i,
  input  logic        cyc_i,
  input  logic        we_i,
  input  logic        supervisor_i,
  input  logic        int_en_i,
  input  logic [31:0] adr_i,
  input  logic [31:0] dat_i,
  input  logic [3:0]  sel_i,
  output logic [31:0] dat_o,
  output logic        ack_o,
  output logic        fault_o,
  output logic [3:0]  interrupt_o
);

  soc_pkg::chipsel_e  chipselect;
  soc_pkg::exc_code_e exception;

  wb_slave_if slv_if [soc_pkg::NUM_TIMERS] ();

  addr_decoder decoder0 (
    .cyc_i        (cyc_i),
    .we_i         (we_i),
    .supervisor_i (supervisor_i),
    .adr_i        (adr_i),
    .dat_i        (dat_i),
    .sel_i        (sel_i),
    .cs_o         (chipselect),
    .fault_o      (fault_o),
    .slv          (slv_if)
  );

  for (genvar i = 0; i < soc_pkg::NUM_TIMERS; i++)
  begin : g_timer
    timer_unit timer0 (
      .sysclock (sysclock),
      .rst_i    (rst_i),
      .bus      (slv_if[i])
    );
  end

  bus_return_irq ret0 (
    .sysclock    (sysclock),
    .rst_i       (rst_i),
    .cyc_i       (cyc_i),
    .int_en_i    (int_en_i),
    .cs_i        (chipselect),
    .fault_i     (fault_o),
    .slv         (slv_if),
    .dat_o       (dat_o),
    .ack_o       (ack_o),
    .interrupt_o (exception)
  );

  assign interrupt_o = exception;

endmodule

//--- dv/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
  output logic sysclock_o
);

  // 20 ns period
  initial
  begin
    sysclock_o = 1'b0;
    forever
      #10 sysclock_o = ~sysclock_o;
  end

endmodule

//--- dv/tb_soc_fabric.sv
`timescale 1ns/1ps

module tb_soc_fabric;

  logic        sysclock;
  logic        rst_i;
  logic        cyc_i;
  logic        we_i;
  logic        supervisor_i;
  logic        int_en_i;
  logic [31:0] adr_i;
  logic [31:0] dat_i;
  logic [3:0]  sel_i;
  logic [31:0] dat_o;
  logic        ack_o;
  logic        fault_o;
  logic [3:0]  interrupt_o;

  clock_gen i_clk (
    .sysclock_o (sysclock)
  );

  soc_fabric i_dut (
    .sysclock     (sysclock),
    .rst_i        (rst_i),
    .cyc_i        (cyc_i),
    .we_i         (we_i),
    .supervisor_i (supervisor_i),
    .int_en_i     (int_en_i),
    .adr_i        (adr_i),
    .dat_i        (dat_i),
    .sel_i        (sel_i),
    .dat_o        (dat_o),
    .ack_o        (ack_o),
    .fault_o      (fault_o),
    .interrupt_o  (interrupt_o)
  );

  task automatic stop_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
      stop_run($sformatf("error at %0d ns: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
      stop_run($sformatf("error at %0d ns: %s is %b, expected %b", $time, what, got, exp));
  endtask

  task automatic check_exc(input soc_pkg::exc_code_e got, input soc_pkg::exc_code_e exp,
                           input string what);
    if (got !== exp)
      stop_run($sformatf("error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  // one bus cycle held open until ack
  task automatic bus_access(input logic write, input logic sup, input logic [31:0] adr,
                            input logic [3:0] sel, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic flt,
                            output soc_pkg::exc_code_e exc);
    int waited;
    @(posedge sysclock);
    cyc_i        <= 1'b1;
    we_i         <= write;
    supervisor_i <= sup;
    adr_i        <= adr;
    sel_i        <= sel;
    dat_i        <= wdata;
    @(negedge sysclock);
    flt = fault_o;
    exc = soc_pkg::exc_code_e'(interrupt_o);
    // ack is registered, so never in the first cycle
    check_flag(ack_o, 1'b0, "ack_o in the first cycle of the access");
    waited = 0;
    while (!ack_o && waited < 16)
    begin
      @(negedge sysclock);
      waited++;
    end
    if (!ack_o)
      stop_run("timeout: ack_o never came within 16 cycles of raising cyc_i");
    else
      rdata = dat_o;
    @(posedge sysclock);
    cyc_i <= 1'b0;
    we_i  <= 1'b0;
    @(negedge sysclock);
    check_flag(ack_o, 1'b0, "ack_o after the access");
  endtask

  task automatic run_access(input logic write, input logic sup, input logic [31:0] adr,
                            input logic [3:0] sel, input logic [31:0] wdata,
                            input logic [31:0] exp_val);
    logic [31:0]        rdata;
    logic               flt;
    logic               exp_fault;
    soc_pkg::exc_code_e exc;
    soc_pkg::exc_code_e exp_exc;
    // reads only fault outside the timer region
    if (write)
      exp_fault = exp_val[0];
    else
      exp_fault = (adr[31:28] != soc_pkg::TIMER_REGION);
    bus_access(write, sup, adr, sel, wdata, rdata, flt, exc);
    check_flag(flt, exp_fault, "fault_o");
    if (exp_fault)
    begin
      if (int_en_i)
        exp_exc = soc_pkg::EXC_MMU;
      else
        exp_exc = soc_pkg::EXC_NONE;
      check_exc(exc, exp_exc, "interrupt_o during a fault");
    end
    if (!write)
      check_word(rdata, exp_val, "dat_o");
  endtask

  task automatic wait_exc(input soc_pkg::exc_code_e exp_code);
    int waited;
    waited = 0;
    @(negedge sysclock);
    while (interrupt_o !== exp_code && waited < 200)
    begin
      @(negedge sysclock);
      waited++;
    end
    if (interrupt_o !== exp_code)
      stop_run($sformatf("timeout: interrupt_o stayed at %0d, never reached %0d",
                         interrupt_o, exp_code));
  endtask

  task automatic set_int_en(input logic en, input soc_pkg::exc_code_e exp_code);
    @(posedge sysclock);
    int_en_i <= en;
    @(negedge sysclock);
    check_exc(soc_pkg::exc_code_e'(interrupt_o), exp_code, "interrupt_o after int_en_i");
  endtask

  initial
  begin
    int          fd;
    int          fields;
    int          line_no;
    string       line;
    logic [7:0]  op;
    logic        sup;
    logic [31:0] adr;
    logic [3:0]  sel;
    logic [31:0] dat;
    logic [31:0] exp_val;
    rst_i        <= 1'b1;
    cyc_i        <= 1'b0;
    we_i         <= 1'b0;
    supervisor_i <= 1'b0;
    int_en_i     <= 1'b0;
    adr_i        <= 32'h0;
    dat_i        <= 32'h0;
    sel_i        <= 4'h0;
    void'($urandom(32'hde88));
    repeat (16) @(posedge sysclock);
    rst_i <= 1'b0;
    @(negedge sysclock);
    check_flag(ack_o, 1'b0, "ack_o after reset");
    check_flag(fault_o, 1'b0, "fault_o after reset");
    check_exc(soc_pkg::exc_code_e'(interrupt_o), soc_pkg::EXC_NONE, "interrupt_o after reset");
    fd = $fopen("dv/fabric_input.txt", "r");
    if (fd == 0)
      stop_run("could not open dv/fabric_input.txt");
    line_no = 0;
    while (!$feof(fd))
    begin
      line = "";
      void'($fgets(line, fd));
      line_no++;
      if (line.len() > 1 && line[0] != "#")
      begin
        fields = $sscanf(line, "%c %h %h %h %h %h", op, sup, adr, sel, dat, exp_val);
        if (fields != 6)
          stop_run($sformatf("line %0d of the data file has %0d fields", line_no, fields));
        case (op)
          "W": run_access(1'b1, sup, adr, sel, dat, exp_val);
          "R": run_access(1'b0, sup, adr, sel, dat, exp_val);
          "X": wait_exc(soc_pkg::exc_code_e'(exp_val[3:0]));
          "E": set_int_en(dat[0], soc_pkg::exc_code_e'(exp_val[3:0]));
          default: stop_run($sformatf("line %0d has an unknown operation", line_no));
        endcase
        // idle gap between operations
        repeat ($urandom_range(3, 0)) @(posedge sysclock);
      end
    end
    $fclose(fd);
    $display(">>> PASS");
    $finish;
  end

endmodule

//--- vlog.f
verilog/soc_pkg.sv
verilog/wb_slave_if.sv
verilog/addr_decoder.sv
verilog/timer_unit.sv
verilog/bus_return_irq.sv
verilog/soc_fabric.sv
dv/clock_gen.sv
dv/tb_soc_fabric.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 -f vlog.f --top-module tb_soc_fabric --Mdir obj_dir

# the log decides the result, tee keeps the pipeline status at zero
./obj_dir/Vtb_soc_fabric 2>&1 | tee sim.log

if grep -qx '>>> PASS' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- dv/fabric_input.txt
# op sup addr sel data expect (hex); W expect = fault flag, R expect = read word
# X waits for expect as exception code; E drives int_en from data, expect = code after
W 1 40000004 f 11111111 0
R 1 40000004 f 00000000 11111111
W 1 40000014 f 22222222 0
R 0 40000014 f 00000000 22222222
W 1 40000024 f 33333333 0
R 1 40000024 f 00000000 33333333
W 1 40000034 f 44444444 0
R 1 40000034 f 00000000 44444444
W 1 40000004 5 aabbccdd 0
R 1 40000004 f 00000000 11bb11dd
E 0 00000000 0 00000001 0
W 1 40000014 f 00000008 0
W 1 40000010 1 00000001 0
X 0 00000000 0 00000000 5
R 1 40000010 f 00000000 00000003
W 1 40000024 f 00000004 0
W 1 40000034 f 00000006 0
W 1 40000020 1 00000001 0
W 1 40000030 1 00000001 0
X 0 00000000 0 00000000 7
W 1 40000030 1 00000000 0
W 1 40000030 1 00000002 0
X 0 00000000 0 00000000 6
R 1 40000030 f 00000000 00000000
E 0 00000000 0 00000000 0
E 0 00000000 0 00000001 6
W 0 40000024 f deadbeef 1
R 1 40000024 f 00000000 00000004
R 1 10000000 f 00000000 00000000
